//--- logic/cpu_macros.svh
// Width and depth macros shared by the core packages and RTL

`default_nettype none

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path

// Architectural register and data word width
`define CPU_REG_WIDTH 32

// Register file

// Index width of a register number
// Also sets the register file depth as two to this power
`define CPU_REGNO_WIDTH 5

// Data memory

// Depth of the data RAM in words
// Word addressed from the ALU result above the byte offset
`define CPU_DMEM_WORDS 64

`endif

`default_nettype wire

//--- logic/cpu_isa_pkg.sv
// Instruction set types: register and word types, opcode, funct, instruction union, ALU op
`include "cpu_macros.svh"

`default_nettype none

package cpu_isa_pkg;

  // Basic architectural types
  typedef logic [`CPU_REGNO_WIDTH-1:0] regno_t;
  typedef logic [`CPU_REG_WIDTH-1:0]   word_t;

  // Primary opcodes, all other values decode as no-op
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  // Function codes under SPECIAL
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_LUI = 3'd6
  } alu_op_e;

  // Register format view
  typedef struct packed {
    opcode_e     opcode;
    regno_t      rs;
    regno_t      rt;
    regno_t      rd;
    logic [4:0]  shamt;
    funct_e      funct;
  } r_fmt_t;

  // Immediate format view
  typedef struct packed {
    opcode_e     opcode;
    regno_t      rs;
    regno_t      rt;
    logic [15:0] imm16;
  } i_fmt_t;

  // One instruction word, two decodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

endpackage

`default_nettype wire

//--- logic/cpu_pipe_pkg.sv
// Pipeline types: decode control, p2 and p3 stage records, bypass source, retire report

`default_nettype none

package cpu_pipe_pkg;

  import cpu_isa_pkg::*;

  // Decode result for one instruction in p1
  typedef struct packed {
    alu_op_e alu_op;
    regno_t  rs;
    regno_t  rt;
    // Zero when nothing is written back
    regno_t  rd;
    // Second ALU operand from the immediate
    logic    use_imm;
    // Already sign or zero extended
    word_t   imm;
    logic    is_load;
    logic    is_store;
  } ctrl_t;

  // Execute stage register
  typedef struct packed {
    ctrl_t ctrl;
    // Operands after bypass selection
    word_t rs_val;
    word_t rt_val;
  } ex_t;

  // Memory stage register
  typedef struct packed {
    regno_t rd;
    // Result or memory byte address
    word_t  alu_y;
    word_t  store_data;
    logic   is_load;
    logic   is_store;
  } mem_t;

  // Destination and value offered by a later stage
  typedef struct packed {
    regno_t dst;
    word_t  data;
  } bypass_t;

  // Report of one instruction leaving the pipe
  typedef struct packed {
    regno_t dst;
    word_t  value;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/regfile.sv
// Register file with two asynchronous read ports and one synchronous write port
`include "cpu_macros.svh"

`default_nettype none

module regfile
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
(
  input  wire logic    clk,
  // Read ports for p1
  input  wire regno_t  rs,
  input  wire regno_t  rt,
  output word_t        rs_data,
  output word_t        rt_data,
  // Write port from the end of p3
  input  wire logic    we,
  input  wire bypass_t wr
);

  localparam int NREGS = 1 << `CPU_REGNO_WIDTH;

  // Register 0 storage exists but is never read
  word_t regs [NREGS];

  // Writes land at the edge closing p3
  always_ff @(posedge clk)
  begin
    if (we && wr.dst != '0)
    begin
      regs[wr.dst] <= wr.data;
    end
  end

  // Register 0 reads as zero
  // Same-cycle writes are covered by the p3 bypass in fwdu
  assign rs_data = (rs == '0) ? '0 : regs[rs];
  assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

//--- logic/decode.sv
// Combinational instruction decoder producing the p1 control record

`default_nettype none

module decode
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
(
  input  wire instr_u instr,
  output ctrl_t       ctrl
);

  // Low when the encoding is not supported
  logic legal;

  always_comb
  begin
    ctrl = '0;
    ctrl.alu_op = ALU_ADD;
    legal = 1'b1;
    if (instr.r_fmt.opcode == OP_SPECIAL)
    begin
      // Register format, result goes to rd
      ctrl.rs = instr.r_fmt.rs;
      ctrl.rt = instr.r_fmt.rt;
      ctrl.rd = instr.r_fmt.rd;
      case (instr.r_fmt.funct)
        FN_ADDU: ctrl.alu_op = ALU_ADD;
        FN_SUBU: ctrl.alu_op = ALU_SUB;
        FN_AND:  ctrl.alu_op = ALU_AND;
        FN_OR:   ctrl.alu_op = ALU_OR;
        FN_XOR:  ctrl.alu_op = ALU_XOR;
        FN_SLT:  ctrl.alu_op = ALU_SLT;
        default: legal = 1'b0;
      endcase
    end
    else
    begin
      // Immediate format, result goes to rt
      ctrl.rs = instr.i_fmt.rs;
      ctrl.rt = instr.i_fmt.rt;
      ctrl.rd = instr.i_fmt.rt;
      ctrl.use_imm = 1'b1;
      // Sign extension unless overridden below
      ctrl.imm = word_t'($signed(instr.i_fmt.imm16));
      case (instr.i_fmt.opcode)
        OP_ADDIU: ctrl.alu_op = ALU_ADD;
        OP_ANDI:
        begin
          ctrl.alu_op = ALU_AND;
          ctrl.imm = word_t'(instr.i_fmt.imm16);
        end
        OP_ORI:
        begin
          ctrl.alu_op = ALU_OR;
          ctrl.imm = word_t'(instr.i_fmt.imm16);
        end
        OP_LUI:
        begin
          ctrl.alu_op = ALU_LUI;
          ctrl.imm = word_t'(instr.i_fmt.imm16);
        end
        OP_LW: ctrl.is_load = 1'b1;
        OP_SW:
        begin
          // rt is store data here, nothing written back
          ctrl.is_store = 1'b1;
          ctrl.rd = '0;
        end
        default: legal = 1'b0;
      endcase
    end
    // Unknown encodings become 0 + 0 into register 0
    if (!legal)
    begin
      ctrl = '0;
      ctrl.alu_op = ALU_ADD;
    end
  end

endmodule

`default_nettype wire

//--- logic/fwdu.sv
// Operand bypass selection for p1 with the load delay slot rule

`default_nettype none

module fwdu
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
(
  // Source registers and raw register file values from p1
  input  wire regno_t  rs,
  input  wire word_t   rs_data,
  input  wire regno_t  rt,
  input  wire word_t   rt_data,
  // Execute stage destination and ALU output
  input  wire bypass_t byp_p2,
  // Load sitting in execute
  input  wire logic    pend_mem_load_p2,
  // Memory stage destination and final result
  input  wire bypass_t byp_p3,
  // Selected operand values
  output word_t        rs_data_p1,
  output word_t        rt_data_p1
);

  // Execute stage result is usable unless it is a load address
  logic p2_usable;

  assign p2_usable = !pend_mem_load_p2;

  // Youngest producer wins, register 0 never bypasses
  always_comb
  begin
    if (rs != '0 && rs == byp_p2.dst && p2_usable)
      rs_data_p1 = byp_p2.data;
    else if (rs != '0 && rs == byp_p3.dst)
      rs_data_p1 = byp_p3.data;
    else
      rs_data_p1 = rs_data;
  end

  // Same rule for rt
  always_comb
  begin
    if (rt != '0 && rt == byp_p2.dst && p2_usable)
      rt_data_p1 = byp_p2.data;
    else if (rt != '0 && rt == byp_p3.dst)
      rt_data_p1 = byp_p3.data;
    else
      rt_data_p1 = rt_data;
  end

  // With a load in p2 the operand falls through to p3 or the register file
  // so the slot after a load sees the old value

endmodule

`default_nettype wire

//--- logic/alu.sv
// Combinational ALU for the execute stage

`default_nettype none

module alu
  import cpu_isa_pkg::*;
(
  input  wire alu_op_e op,
  input  wire word_t   a,
  input  wire word_t   b,
  output word_t        y
);

  // Signed compare for slt
  logic lt_signed;

  assign lt_signed = $signed(a) < $signed(b);

  always_comb
  begin
    case (op)
      // Add and subtract wrap, no overflow trap
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      // Bitwise logic
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      // Set on less than, result 0 or 1
      ALU_SLT: y = word_t'(lt_signed);
      // Immediate into the upper half
      ALU_LUI: y = b << 16;
      default: y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/dmem.sv
// Word-addressed data RAM and p3 result selection
`include "cpu_macros.svh"

`default_nettype none

module dmem
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
(
  input  wire logic clk,
  // Memory stage register and its valid bit
  input  wire mem_t stage,
  input  wire logic valid,
  // Value written back, bypassed and retired
  output word_t     result
);

  localparam int AW = $clog2(`CPU_DMEM_WORDS);

  word_t ram [`CPU_DMEM_WORDS];

  // Word index above the byte offset
  logic [AW-1:0] addr;

  assign addr = stage.alu_y[AW+1:2];

  // Store at the edge that closes p3
  always_ff @(posedge clk)
  begin
    if (valid && stage.is_store)
    begin
      ram[addr] <= stage.store_data;
    end
  end

  // Read is combinational on the address
  // A store reports its data, everything else the ALU result
  always_comb
  begin
    if (stage.is_load)
      result = ram[addr];
    else if (stage.is_store)
      result = stage.store_data;
    else
      result = stage.alu_y;
  end

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
// Pipeline top with decode, execute and memory stage registers and the retire report

`default_nettype none

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  // Instruction strobe, accepted on every edge with in_valid high
  input  wire logic   in_valid,
  input  wire instr_u in_instr,
  // One strobe per instruction, three edges after acceptance
  output logic        retire_valid,
  output retire_t     retire
);

  // p1 decode and operands
  ctrl_t   ctrl_p1;
  word_t   rs_raw;
  word_t   rt_raw;
  word_t   rs_p1;
  word_t   rt_p1;

  // Stage registers and valid bits
  ex_t     ex_q;
  mem_t    mem_q;
  logic    ex_valid;
  logic    mem_valid;

  // p2 ALU signals
  word_t   alu_b;
  word_t   alu_y;

  // p3 result and bypass sources
  word_t   result_p3;
  bypass_t byp_p2;
  bypass_t byp_p3;

  decode u_decode (
    .instr (in_instr),
    .ctrl  (ctrl_p1)
  );

  // Register file written with the p3 result
  regfile u_regfile (
    .clk     (clk),
    .rs      (ctrl_p1.rs),
    .rt      (ctrl_p1.rt),
    .rs_data (rs_raw),
    .rt_data (rt_raw),
    .we      (mem_valid),
    .wr      (byp_p3)
  );

  // Invalid stages offer register 0, which never matches
  assign byp_p2.dst  = ex_valid ? ex_q.ctrl.rd : '0;
  assign byp_p2.data = alu_y;
  assign byp_p3.dst  = mem_valid ? mem_q.rd : '0;
  assign byp_p3.data = result_p3;

  fwdu u_fwdu (
    .rs               (ctrl_p1.rs),
    .rs_data          (rs_raw),
    .rt               (ctrl_p1.rt),
    .rt_data          (rt_raw),
    .byp_p2           (byp_p2),
    .pend_mem_load_p2 (ex_valid && ex_q.ctrl.is_load),
    .byp_p3           (byp_p3),
    .rs_data_p1       (rs_p1),
    .rt_data_p1       (rt_p1)
  );

  // Immediate or rt as second operand
  assign alu_b = ex_q.ctrl.use_imm ? ex_q.ctrl.imm : ex_q.rt_val;

  alu u_alu (
    .op (ex_q.ctrl.alu_op),
    .a  (ex_q.rs_val),
    .b  (alu_b),
    .y  (alu_y)
  );

  dmem u_dmem (
    .clk    (clk),
    .stage  (mem_q),
    .valid  (mem_valid),
    .result (result_p3)
  );

  // Valid bits advance one stage per edge, no stalls
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ex_valid     <= 1'b0;
      mem_valid    <= 1'b0;
      retire_valid <= 1'b0;
    end
    else
    begin
      ex_valid     <= in_valid;
      mem_valid    <= ex_valid;
      retire_valid <= mem_valid;
    end
  end

  // Payload follows the valid bits
  always_ff @(posedge clk)
  begin
    ex_q.ctrl        <= ctrl_p1;
    ex_q.rs_val      <= rs_p1;
    ex_q.rt_val      <= rt_p1;
    mem_q.rd         <= ex_q.ctrl.rd;
    mem_q.alu_y      <= alu_y;
    mem_q.store_data <= ex_q.rt_val;
    mem_q.is_load    <= ex_q.ctrl.is_load;
    mem_q.is_store   <= ex_q.ctrl.is_store;
    // Captured together with the register file write
    retire.dst       <= mem_q.rd;
    retire.value     <= result_p3;
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Testbench clock with a 4 ns period and a synchronous reset held for 8 rising edges

`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, 2 ns per phase
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset is sampled high on the first 8 rising edges
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_cpu_core.sv
// CPU core testbench with LCG stimulus, a cycle-level reference model and retire checks
`include "cpu_macros.svh"

`default_nettype none

module tb_cpu_core
  import cpu_isa_pkg::*;
  import cpu_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // One instruction as the model tracks it through p2 and p3
  typedef struct packed {
    logic   valid;
    regno_t dst;
    logic   is_load;
    logic   is_store;
    // ALU result in p2 and final value once it leaves p3
    word_t  value;
    word_t  store_data;
  } slot_t;

  logic    clk;
  logic    reset;
  logic    in_valid;
  instr_u  in_instr;
  logic    retire_valid;
  retire_t retire;

  // Architectural state of the model
  word_t   regs_m [32];
  word_t   ram_m [`CPU_DMEM_WORDS];
  // Slots hold p2, p3 and the instruction retiring now
  slot_t   pipe [3];

  // Expected retire records written by the model and read by the checker
  retire_t    expect_ring [4];
  logic [1:0] ring_wr;
  logic [1:0] ring_rd;

  int          errors;
  int          checks;
  int          timeouts;
  int          strobes;
  int          retires;
  logic [31:0] lcg_state;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  cpu_core DUT (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  // Numerical Recipes LCG step
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t r_word(input logic [5:0] fn, input regno_t rs, input regno_t rt,
                                   input regno_t rd);
    return {6'h00, rs, rt, rd, 5'h00, fn};
  endfunction

  function automatic word_t i_word(input logic [5:0] op, input regno_t rs, input regno_t rt,
                                   input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // RAM fill value with every address bit shown twice
  function automatic logic [15:0] fill_pattern(input logic [5:0] idx);
    return {idx, 4'h5, idx} ^ 16'hc3a6;
  endfunction

  // One random instruction over registers 0 to 7
  function automatic word_t random_instr();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [15:0] h1;
    logic [15:0] h2;
    regno_t      rs;
    regno_t      rt;
    regno_t      rd;
    logic [15:0] addr;
    word_t       w;
    r1 = next_rand();
    r2 = next_rand();
    // Only the upper halves since the low LCG bits repeat quickly
    h1 = r1[31:16];
    h2 = r2[31:16];
    rs = {2'b00, h1[2:0]};
    rt = {2'b00, h1[5:3]};
    rd = {2'b00, h1[8:6]};
    // Half the accesses hit four hot words so stores and loads meet
    addr = h1[9] ? {12'h000, h1[11:10], 2'b00} : {8'h00, h2[5:0], 2'b00};
    case (h1[15:12])
      4'd0: w = r_word(FN_ADDU, rs, rt, rd);
      4'd1: w = r_word(FN_SUBU, rs, rt, rd);
      4'd2: w = r_word(FN_AND, rs, rt, rd);
      4'd3: w = r_word(FN_OR, rs, rt, rd);
      4'd4: w = r_word(FN_XOR, rs, rt, rd);
      4'd5: w = r_word(FN_SLT, rs, rt, rd);
      4'd6: w = i_word(OP_ADDIU, rs, rt, h2);
      4'd7: w = i_word(OP_ANDI, rs, rt, h2);
      4'd8: w = i_word(OP_ORI, rs, rt, h2);
      4'd9: w = i_word(OP_LUI, rs, rt, h2);
      4'd10, 4'd11: w = i_word(OP_LW, 5'd0, rt, addr);
      4'd12, 4'd13: w = i_word(OP_SW, 5'd0, rt, addr);
      // SPECIAL with funct 0 is an unsupported shift
      4'd14: w = r_word(6'h00, rs, rt, rd);
      // Opcodes 0x30 to 0x37 are unknown
      default: w = {3'b110, h1[11:9], h2, h1[9:0]};
    endcase
    return w;
  endfunction

  // Execute one MIPS instruction word on its operand values
  function automatic slot_t predict_exec(input word_t w, input word_t a, input word_t b);
    slot_t s;
    word_t sext;
    word_t zext;
    logic  to_rt;
    s = '0;
    sext = {{16{w[15]}}, w[15:0]};
    zext = {16'h0000, w[15:0]};
    to_rt = 1'b1;
    case (w[31:26])
      6'h09: s.value = a + sext;
      6'h0c: s.value = a & zext;
      6'h0d: s.value = a | zext;
      6'h0f: s.value = {w[15:0], 16'h0000};
      6'h23: s.is_load = 1'b1;
      6'h2b: s.is_store = 1'b1;
      default: to_rt = 1'b0;
    endcase
    // Loads and stores carry their byte address
    if (s.is_load || s.is_store)
      s.value = a + sext;
    if (s.is_store)
      s.store_data = b;
    if (to_rt && !s.is_store)
      s.dst = w[20:16];
    // Register format writes rd
    if (w[31:26] == 6'h00)
    begin
      s.dst = w[15:11];
      case (w[5:0])
        6'h21: s.value = a + b;
        6'h23: s.value = a - b;
        6'h24: s.value = a & b;
        6'h25: s.value = a | b;
        6'h26: s.value = a ^ b;
        6'h2a: s.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: s.dst = 5'd0;
      endcase
    end
    return s;
  endfunction

  // Operand value seen in p1
  function automatic word_t bypass_operand(input regno_t r, input slot_t p2, input slot_t p3);
    if (r == 5'd0)
      return '0;
    // A load in p2 has no data yet so the older value is used
    if (p2.valid && p2.dst == r && !p2.is_load)
      return p2.value;
    if (p3.valid && p3.dst == r)
      return p3.value;
    return regs_m[r];
  endfunction

  task automatic issue(input word_t w);
    @(posedge clk);
    in_valid <= 1'b1;
    in_instr <= w;
  endtask

  // Model advances on the same edges as the DUT with pre-edge values
  always @(posedge clk)
  begin : model_step
    slot_t      p3;
    word_t      w;
    word_t      a;
    word_t      b;
    logic [5:0] idx;
    if (reset !== 1'b0)
    begin
      pipe[0] = '0;
      pipe[1] = '0;
      pipe[2] = '0;
      ring_wr = 2'd0;
      strobes = 0;
    end
    else
    begin
      // Final value of the instruction leaving p3
      p3 = pipe[1];
      idx = p3.value[7:2];
      if (p3.is_load)
        p3.value = ram_m[idx];
      else if (p3.is_store)
        p3.value = p3.store_data;
      // Instruction sampled at this edge
      w = in_instr;
      a = bypass_operand(w[25:21], pipe[0], p3);
      b = bypass_operand(w[20:16], pipe[0], p3);
      // Memory and register writes at the end of p3
      if (p3.valid && p3.is_store)
        ram_m[idx] = p3.store_data;
      if (p3.valid && p3.dst != 5'd0)
        regs_m[p3.dst] = p3.value;
      pipe[2] = p3;
      pipe[1] = pipe[0];
      pipe[0] = predict_exec(w, a, b);
      pipe[0].valid = in_valid;
      if (in_valid)
        strobes++;
      if (p3.valid)
      begin
        expect_ring[ring_wr].dst = p3.dst;
        expect_ring[ring_wr].value = p3.value;
        ring_wr = ring_wr + 2'd1;
      end
    end
  end

  // Outputs are compared mid-cycle
  always @(negedge clk)
  begin : retire_check
    retire_t want;
    if (reset !== 1'b0)
    begin
      ring_rd = 2'd0;
      errors = 0;
      checks = 0;
      retires = 0;
    end
    else
    begin
      checks++;
      assert (retire_valid === pipe[2].valid)
      else
      begin
        errors++;
        $display("error %0t: retire_valid is %b, expected %b", $time, retire_valid,
                 pipe[2].valid);
      end
      if (retire_valid === 1'b1)
      begin
        retires++;
        if (ring_rd == ring_wr)
        begin
          errors++;
          $display("A retire strobe came with no instruction outstanding");
        end
        else
        begin
          want = expect_ring[ring_rd];
          ring_rd = ring_rd + 2'd1;
          checks++;
          assert (retire === want)
          else
          begin
            errors++;
            $display("error %0t: retired dst %0d value %h, expected dst %0d value %h",
                     $time, retire.dst, retire.value, want.dst, want.value);
          end
        end
      end
    end
  end

  initial
  begin : stimulus
    int          n;
    int          waited;
    logic [31:0] r;
    in_valid = 1'b0;
    in_instr = '0;
    lcg_state = 32'h98b25264;
    timeouts = 0;
    waited = 0;
    // Reset is read only after a rising edge
    do
    begin
      @(posedge clk);
      waited++;
    end
    while (reset !== 1'b0 && waited < 40);
    if (reset !== 1'b0)
    begin
      $display("Timeout waiting for reset to be released");
      timeouts++;
    end
    else
    begin
      // Fill every RAM word through r1
      for (n = 0; n < `CPU_DMEM_WORDS; n++)
      begin
        issue(i_word(OP_ORI, 5'd0, 5'd1, fill_pattern(6'(n))));
        issue(i_word(OP_SW, 5'd0, 5'd1, {8'h00, 6'(n), 2'b00}));
      end
      // Registers 1 to 7 where each ori depends on the lui just before it
      for (n = 1; n < 8; n++)
      begin
        r = next_rand();
        issue(i_word(OP_LUI, 5'd0, 5'(n), r[31:16]));
        issue(i_word(OP_ORI, 5'(n), 5'(n), r[23:8]));
      end
      // Random traffic with about 80% strobes
      for (n = 0; n < 3000; n++)
      begin
        r = next_rand();
        @(posedge clk);
        in_valid <= (r[31:16] < 16'd52429);
        in_instr <= random_instr();
      end
      @(posedge clk);
      in_valid <= 1'b0;
      // Drain the pipe
      waited = 0;
      do
      begin
        @(posedge clk);
        waited++;
      end
      while (retires != strobes && waited < 20);
      if (retires != strobes)
      begin
        $display("Timeout, %0d of %0d instructions never retired", strobes - retires, strobes);
        timeouts++;
      end
      // A few idle cycles catch stray retire strobes
      repeat (3) @(posedge clk);
    end
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/regfile.sv
logic/decode.sv
logic/fwdu.sv
logic/alu.sv
logic/dmem.sv
logic/cpu_core.sv
test/tb_clock.sv
test/tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cpu_core -f sim.f -o tb_cpu_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/tb_cpu_core_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -x "Finished with no errors"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
